// File: Makefile
# Verilator build and run for the light period meter

VERILATOR ?= verilator
TOP       ?= tb_light_period
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Testbench passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation result found in $(LOG)"; \
	else \
		echo "no pass line in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
hdl/light_period_pkg.sv
hdl/als_spi_receiver.sv
hdl/crossing_period_meter.sv
hdl/hex_display.sv
hdl/light_period_top.sv
verification/als_sensor_model.sv
verification/tb_light_period.sv

// File: hdl/als_spi_receiver.sv
`timescale 1ns/1ps
`default_nettype none

// reads the light sensor ADC over cs, sck and sdo
// sck idles high, the sensor moves sdo after a falling edge and
// the frame bit is taken when this block drives sck high again
module als_spi_receiver
#(
    parameter int sck_half_cycles  = 2,   // clk cycles per sck half period
    parameter int frame_gap_cycles = 8    // cs high time between frames, at least 1
)
(
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       sdo,
    output logic                      cs,
    output logic                      sck,
    output light_period_pkg::sample_t sample,
    output logic                      sample_valid
);

    import light_period_pkg::*;

    localparam int div_width = $clog2(sck_half_cycles + 1);
    localparam int gap_width = $clog2(frame_gap_cycles + 1);
    localparam int bit_width = $clog2(sample_width);

    localparam logic [div_width-1:0] div_last = div_width'(sck_half_cycles - 1);
    localparam logic [gap_width-1:0] gap_last = gap_width'(frame_gap_cycles - 1);
    localparam logic [bit_width-1:0] bit_last = bit_width'(sample_width - 1);

    typedef enum logic [1:0]
    {
        st_gap,     // cs high, waiting between frames
        st_shift,   // cs low, sck running
        st_done     // last bit in, frame handed over next edge
    } state_t;

    state_t                 state;
    logic [gap_width-1:0]   gap_cnt;
    logic [div_width-1:0]   div_cnt;
    logic [bit_width-1:0]   bit_cnt;   // rising edges seen in this frame
    sample_t                shift_reg;
    logic                   div_wrap;
    logic                   sck_rise;

    assign div_wrap = (state == st_shift) && (div_cnt == div_last);
    assign sck_rise = div_wrap && !sck;  // sck goes high on this clock edge

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state        <= st_gap;
            gap_cnt      <= '0;
            div_cnt      <= '0;
            bit_cnt      <= '0;
            cs           <= 1'b1;
            sck          <= 1'b1;
            sample       <= '0;
            sample_valid <= 1'b0;
        end
        else
        begin
            sample_valid <= 1'b0;

            case (state)
                st_gap:
                begin
                    if (gap_cnt == gap_last)
                    begin
                        gap_cnt <= '0;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        cs      <= 1'b0;   // frame begins with sck still high
                        state   <= st_shift;
                    end
                    else
                        gap_cnt <= gap_cnt + 1'b1;
                end

                st_shift:
                begin
                    if (div_wrap)
                    begin
                        div_cnt <= '0;
                        sck     <= ~sck;
                        if (sck_rise)
                        begin
                            if (bit_cnt == bit_last)
                                state <= st_done;   // sck stays high from here on
                            else
                                bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    else
                        div_cnt <= div_cnt + 1'b1;
                end

                st_done:
                begin
                    // cs, sample and the strobe all change on this one edge
                    cs           <= 1'b1;
                    sample       <= shift_reg;
                    sample_valid <= 1'b1;
                    gap_cnt      <= '0;
                    state        <= st_gap;
                end

                default:
                    state <= st_gap;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (sck_rise)
            shift_reg <= {shift_reg[sample_width-2:0], sdo};  // MSB arrives first
    end

    // the clock line must be parked high whenever the sensor is deselected
    a_sck_idle_high: assert property (@(posedge clk) disable iff (reset) cs |-> sck)
        else $error("sck low while cs is high");

    a_valid_single: assert property
        (@(posedge clk) disable iff (reset) sample_valid |=> !sample_valid)
        else $error("sample_valid high in two consecutive cycles");

endmodule

`default_nettype wire

// File: hdl/crossing_period_meter.sv
`timescale 1ns/1ps
`default_nettype none

// measures the clk cycles between upward crossings of a brightness level
// a crossing needs the old sample strictly below and the new one strictly above
module crossing_period_meter
#(
    parameter int                        counter_width = 24,
    parameter light_period_pkg::sample_t threshold     = light_period_pkg::default_threshold
)
(
    input  wire                       clk,
    input  wire                       reset,
    input  light_period_pkg::sample_t sample,
    input  wire                       sample_valid,
    output logic [counter_width-1:0]  period,
    output logic                      period_valid
);

    import light_period_pkg::*;

    localparam logic [counter_width-1:0] count_one = counter_width'(1);
    localparam logic [counter_width-1:0] count_max = {counter_width{1'b1}};

    sample_t                   prev_sample;   // sample seen at the last strobe
    logic [counter_width-1:0]  counter;
    logic                      armed;         // a first crossing has been seen
    logic                      above;
    logic                      below;
    logic                      crossing;

    assign above    = sample > threshold;
    assign below    = prev_sample < threshold;
    assign crossing = sample_valid && above && below;

    // a sample exactly at the threshold never counts on either side
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            prev_sample <= '0;
        else if (sample_valid)
            prev_sample <= sample;
    end

    // counter starts at 1 on a crossing so that it holds the cycle distance
    // when the next crossing comes along
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            counter <= '0;
        else if (crossing)
            counter <= count_one;
        else if (counter != count_max)
            counter <= counter + count_one;   // sticks at all ones
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            armed <= 1'b0;
        else if (crossing)
            armed <= 1'b1;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            period       <= '0;
            period_valid <= 1'b0;
        end
        else
        begin
            period_valid <= crossing && armed;  // the first crossing only arms
            if (crossing && armed)
                period <= counter;
        end
    end

    // a result only ever follows a frame strobe by exactly one cycle
    a_valid_after_sample: assert property
        (@(posedge clk) disable iff (reset) period_valid |-> $past(sample_valid))
        else $error("period_valid without a sample_valid in the previous cycle");

endmodule

`default_nettype wire

// File: hdl/hex_display.sv
`timescale 1ns/1ps
`default_nettype none

// shows a value as hex digits on active-low seven-segment outputs
// digit 0 carries the lowest nibble
module hex_display
#(
    parameter int digit_count = 6
)
(
    input  wire                                       clk,
    input  wire                                       reset,
    input  wire  [digit_count*4-1:0]                  value,
    output light_period_pkg::seg_t [digit_count-1:0]  hex
);

    import light_period_pkg::*;

    // segment bits are g f e d c b a, a zero lights the segment
    function automatic seg_t nibble_to_seg(input logic [3:0] nibble);
        seg_t pattern;
        case (nibble)
            4'h0:    pattern = 7'b100_0000;
            4'h1:    pattern = 7'b111_1001;
            4'h2:    pattern = 7'b010_0100;
            4'h3:    pattern = 7'b011_0000;
            4'h4:    pattern = 7'b001_1001;
            4'h5:    pattern = 7'b001_0010;
            4'h6:    pattern = 7'b000_0010;
            4'h7:    pattern = 7'b111_1000;
            4'h8:    pattern = 7'b000_0000;
            4'h9:    pattern = 7'b001_0000;
            4'ha:    pattern = 7'b000_1000;
            4'hb:    pattern = 7'b000_0011;   // lower case b
            4'hc:    pattern = 7'b100_0110;
            4'hd:    pattern = 7'b010_0001;   // lower case d
            4'he:    pattern = 7'b000_0110;
            default: pattern = 7'b000_1110;   // F
        endcase
        return pattern;
    endfunction

    // every digit is registered so the outputs change one cycle after value
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < digit_count; i++)
                hex[i] <= nibble_to_seg(4'h0);   // blank value reads as all zeros
        end
        else
        begin
            for (int i = 0; i < digit_count; i++)
                hex[i] <= nibble_to_seg(value[4*i +: 4]);
        end
    end

endmodule

`default_nettype wire

// File: hdl/light_period_pkg.sv
`default_nettype none

// types and defaults shared by the ambient light period meter
package light_period_pkg;

    // one ADC frame on the serial link
    localparam int sample_width = 16;

    // one seven-segment digit without the decimal point
    localparam int seg_width = 7;

    // width of the brightness bar taken from the top of each sample
    localparam int level_width = 10;

    // raw frame word, the first bit on sdo ends up in the MSB
    typedef logic [sample_width-1:0] sample_t;

    // segment pattern, active low, bit order g f e d c b a
    typedef logic [seg_width-1:0] seg_t;

    // crossing level used by the top level unless overridden
    localparam sample_t default_threshold = 16'h1000;

endpackage

`default_nettype wire

// File: hdl/light_period_top.sv
`timescale 1ns/1ps
`default_nettype none

// light pulse period meter
// sensor frames come in over the serial link, the time between
// upward threshold crossings goes out as a number and as hex digits
module light_period_top
#(
    parameter int                        sck_half_cycles  = 2,
    parameter int                        frame_gap_cycles = 8,
    parameter int                        counter_width    = 24,   // multiple of 4
    parameter light_period_pkg::sample_t threshold        = light_period_pkg::default_threshold,
    localparam int                       digit_count      = counter_width / 4
)
(
    input  wire                                         clk,
    input  wire                                         reset,
    input  wire                                         sdo,
    output logic                                        cs,
    output logic                                        sck,
    output logic [light_period_pkg::level_width-1:0]    level,
    output logic [counter_width-1:0]                    period,
    output logic                                        period_valid,
    output light_period_pkg::seg_t [digit_count-1:0]    hex
);

    import light_period_pkg::*;

    sample_t sample;
    logic    sample_valid;

    als_spi_receiver
    #(
        .sck_half_cycles  (sck_half_cycles),
        .frame_gap_cycles (frame_gap_cycles)
    )
    i_als_spi_receiver
    (
        .clk          (clk),
        .reset        (reset),
        .sdo          (sdo),
        .cs           (cs),
        .sck          (sck),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    // brightness bar from the most significant sample bits
    assign level = sample[sample_width-1 -: level_width];

    crossing_period_meter
    #(
        .counter_width (counter_width),
        .threshold     (threshold)
    )
    i_crossing_period_meter
    (
        .clk          (clk),
        .reset        (reset),
        .sample       (sample),
        .sample_valid (sample_valid),
        .period       (period),
        .period_valid (period_valid)
    );

    hex_display
    #(
        .digit_count (digit_count)
    )
    i_hex_display
    (
        .clk   (clk),
        .reset (reset),
        .value (period),
        .hex   (hex)
    );

endmodule

`default_nettype wire

// File: verification/als_sensor_model.sv
`timescale 1ns/1ps
`default_nettype none

// behavioral ambient light sensor on the three-wire link
// each frame plays the next queued word MSB first, zero once the queue runs dry
module als_sensor_model
(
    input  wire clk,
    input  wire cs,
    input  wire sck,
    output wire sdo,
    output wire frame_error
);

    import light_period_pkg::*;

    sample_t word_queue[$];       // filled by the testbench before the run
    int      read_idx    = 0;
    int      rise_count  = 0;     // sck rising edges in the current frame
    sample_t shift_word  = '0;
    logic    cs_q        = 1'b1;
    logic    sck_q       = 1'b1;
    logic    sdo_r       = 1'b0;
    logic    error_r     = 1'b0;  // sticky, stays set once a frame was malformed

    assign sdo         = sdo_r;
    assign frame_error = error_r;

    task automatic push_word(input sample_t word);
        word_queue.push_back(word);
    endtask

    // cs and sck move on the rising clk edge, so they are stable here
    always @(negedge clk)
    begin
        if (cs_q && !cs)
        begin
            if (read_idx < word_queue.size())
            begin
                shift_word <= word_queue[read_idx];
                read_idx   <= read_idx + 1;
            end
            else
                shift_word <= '0;
            rise_count <= 0;
        end
        else if (!cs)
        begin
            if (sck_q && !sck)
            begin
                sdo_r      <= shift_word[sample_width-1];   // new bit after each falling edge
                shift_word <= shift_word << 1;
            end
            if (!sck_q && sck)
                rise_count <= rise_count + 1;
        end

        if (!cs_q && cs && rise_count != sample_width)
            error_r <= 1'b1;

        cs_q  <= cs;
        sck_q <= sck;
    end

endmodule

`default_nettype wire

// File: verification/tb_light_period.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for the light period meter
// a sensor model plays queued frames and a monitor checks level, period and hex
// against a reference model of the crossing, arming and saturation rules
module tb_light_period;

    import light_period_pkg::*;

    localparam int      counter_width    = 16;   // saturation is reachable in a short run
    localparam int      digit_count      = counter_width / 4;
    localparam int      sck_half_cycles  = 2;
    localparam int      frame_gap_cycles = 8;
    localparam int      reset_cycles     = 16;
    localparam int      random_frames    = 80;
    localparam int      hold_frames      = 920;  // bright for well over 65535 cycles
    localparam int      frame_cycles     = 32 * sck_half_cycles + frame_gap_cycles + 4;
    localparam sample_t threshold        = default_threshold;

    typedef logic [counter_width-1:0] period_t;
    typedef logic [level_width-1:0]   level_t;

    logic                   clk          = 1'b0;
    logic                   reset        = 1'b1;
    wire                    sdo;
    wire                    cs;
    wire                    sck;
    wire                    frame_error;
    level_t                 level;
    period_t                period;
    logic                   period_valid;
    seg_t [digit_count-1:0] hex;

    sample_t sent_words[$];
    int      rise_cycles[$];       // cycle number of every cs rising edge
    int      cycle           = 0;
    int      cycle_limit     = 0;
    int      frames_seen     = 0;
    logic    cs_q            = 1'b1;
    logic    valid_due       = 1'b0;
    logic    hex_due         = 1'b0;
    logic    saturation_seen = 1'b0;
    period_t expected_value  = '0;
    period_t hex_value       = '0;
    sample_t level_word      = '0;

    light_period_top
    #(
        .sck_half_cycles  (sck_half_cycles),
        .frame_gap_cycles (frame_gap_cycles),
        .counter_width    (counter_width),
        .threshold        (threshold)
    )
    i_light_period_top
    (
        .clk          (clk),
        .reset        (reset),
        .sdo          (sdo),
        .cs           (cs),
        .sck          (sck),
        .level        (level),
        .period       (period),
        .period_valid (period_valid),
        .hex          (hex)
    );

    als_sensor_model i_als_sensor_model
    (
        .clk         (clk),
        .cs          (cs),
        .sck         (sck),
        .sdo         (sdo),
        .frame_error (frame_error)
    );

    initial
    begin
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Testbench failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_sample(input string name, input level_t expected, input level_t actual);
        if (actual !== expected)
        begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_period(input string name, input period_t expected,
                                input period_t actual);
        if (actual !== expected)
        begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_hex(input string name, input seg_t expected, input seg_t actual);
        if (actual !== expected)
        begin
            $display("** Error: %s expected %b actual %b", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_strobe(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("** Error: %s expected %b actual %b", name, expected, actual);
            stop_with_failure();
        end
    endtask

    // standard seven-segment glyphs that are active low in g f e d c b a order
    function automatic seg_t segments_for(input logic [3:0] nibble);
        seg_t glyph;
        case (nibble)
            4'h0:    glyph = 7'b1000000;
            4'h1:    glyph = 7'b1111001;
            4'h2:    glyph = 7'b0100100;
            4'h3:    glyph = 7'b0110000;
            4'h4:    glyph = 7'b0011001;
            4'h5:    glyph = 7'b0010010;
            4'h6:    glyph = 7'b0000010;
            4'h7:    glyph = 7'b1111000;
            4'h8:    glyph = 7'b0000000;
            4'h9:    glyph = 7'b0010000;
            4'ha:    glyph = 7'b0001000;
            4'hb:    glyph = 7'b0000011;
            4'hc:    glyph = 7'b1000110;
            4'hd:    glyph = 7'b0100001;
            4'he:    glyph = 7'b0000110;
            default: glyph = 7'b0001110;
        endcase
        return glyph;
    endfunction

    function automatic sample_t frame_word(input int frame);
        if (frame < sent_words.size())
            return sent_words[frame];
        else
            return '0;   // the sensor sends zeros once the queue is empty
    endfunction

    // replays every frame up to this one and returns 1 when the frame yields a period
    function automatic bit expected_period(input int frame, output period_t value);
        sample_t prev;
        sample_t word;
        bit      armed;
        bit      result;
        int      last_rise;
        int      distance;
        prev      = '0;
        armed     = 1'b0;
        result    = 1'b0;
        last_rise = 0;
        value     = '0;
        for (int k = 0; k <= frame; k++)
        begin
            word   = frame_word(k);
            result = 1'b0;
            if (word > threshold && prev < threshold)
            begin
                if (armed)
                begin
                    distance = rise_cycles[k] - last_rise;
                    value    = (distance > 2**counter_width - 1) ? '1 : period_t'(distance);
                    result   = 1'b1;
                end
                armed     = 1'b1;
                last_rise = rise_cycles[k];
            end
            prev = word;
        end
        return result;
    endfunction

    // biased towards the threshold so that crossings happen often
    function automatic sample_t random_word();
        int unsigned pick;
        sample_t     word;
        pick = $urandom_range(0, 3);
        case (pick)
            0:       word = sample_t'($urandom);
            1:       word = threshold;
            2:       word = sample_t'($urandom_range(0, 32'h0fff));
            default: word = sample_t'($urandom_range(32'h1001, 32'h1fff));
        endcase
        return word;
    endfunction

    task automatic send_word(input sample_t word);
        sent_words.push_back(word);
        i_als_sensor_model.push_word(word);
    endtask

    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (cycle > cycle_limit)
        begin
            $display("timeout after %0d cycles, not all frames came through", cycle);
            stop_with_failure();
        end
        else if (frame_error)
        begin
            $display("sensor model saw a frame without exactly 16 sck rising edges");
            stop_with_failure();
        end
    end

    // all DUT outputs are settled at the falling edge where these checks run
    always @(negedge clk)
    begin
        if (hex_due)
        begin
            for (int d = 0; d < digit_count; d++)
                check_hex($sformatf("hex digit %0d", d),
                          segments_for(hex_value[4*d +: 4]), hex[d]);
        end
        hex_due   = valid_due;
        hex_value = expected_value;
        check_strobe("period_valid", valid_due, period_valid);
        if (valid_due)
        begin
            check_period("period", expected_value, period);
            if (expected_value == '1)
                saturation_seen = 1'b1;
        end
        valid_due = 1'b0;
        if (cs && !cs_q)
        begin
            rise_cycles.push_back(cycle);
            level_word = frame_word(frames_seen);
            check_sample("level", level_word[sample_width-1 -: level_width], level);
            valid_due = expected_period(frames_seen, expected_value);   // due next cycle
            frames_seen++;
        end
        cs_q = cs;
    end

    initial
    begin
        void'($urandom(9));
        // alternating dark and bright frames where the first crossing only arms
        send_word(16'h0800);
        send_word(16'h2400);
        send_word(16'h00ff);
        send_word(16'hf00f);
        send_word(16'h0fff);
        send_word(16'h1001);
        send_word(16'h0000);
        send_word(16'h8000);
        // a word equal to the threshold is neither below nor above it
        send_word(16'h1000);
        send_word(16'h3000);
        send_word(16'h0200);
        send_word(16'h1000);
        send_word(16'h2000);
        send_word(16'h0fff);
        send_word(16'h1001);
        for (int i = 0; i < random_frames; i++)
            send_word(random_word());
        // one crossing, a long bright stretch, then a crossing that must saturate
        send_word(16'h0010);
        send_word(16'h2000);
        for (int i = 0; i < hold_frames; i++)
            send_word(sample_t'($urandom_range(32'h2000, 32'hffff)));
        send_word(16'h0010);
        send_word(16'h4000);
        cycle_limit = (sent_words.size() + 4) * frame_cycles + reset_cycles + 200;

        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        check_strobe("cs after reset", 1'b1, cs);
        check_strobe("sck after reset", 1'b1, sck);
        check_strobe("period_valid after reset", 1'b0, period_valid);
        for (int d = 0; d < digit_count; d++)
            check_hex($sformatf("hex digit %0d after reset", d), segments_for(4'h0), hex[d]);

        while (frames_seen <= sent_words.size())
            @(negedge clk);
        repeat (3) @(negedge clk);

        if (saturation_seen)
        begin
            $display("Testbench passed");
            $finish;
        end
        else
        begin
            $display("the saturated period was never reported");
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire
